// File: rs.f
+incdir+source
source/rs_pkg.sv
source/alu_unit.sv
source/mult_unit.sv
source/result_select.sv
source/rs_slot.sv
source/rs_top.sv
sim/rs_tb.sv

// File: Makefile
# Verilator build of the reservation station testbench

BIN     := obj_dir/Vrs_tb
SOURCES := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(BIN): rs.f $(SOURCES)
	verilator --binary --timing --assert -f rs.f --top-module rs_tb -o Vrs_tb

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/rs_tb.sv
/*
 * directed testbench for the reservation station; a monitor records every
 * broadcast by tag and each test compares it with a reference of the opcode
 */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module rs_tb import rs_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int NUM_TAGS = 1 << `RS_TAG_BITS;

    typedef logic [`RS_XLEN-1:0]     word_t;
    typedef logic [`RS_TAG_BITS-1:0] tag_t;

    logic      clock;
    logic      reset;
    logic      squash;
    logic      dispatch_valid;
    logic      dispatch_ready;
    dispatch_t dispatch_in;
    cdb_t      cdb_out;

    int    cycle = 0;
    int    errors = 0;
    int    monitor_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    seen_count [NUM_TAGS] = '{default: 0};
    word_t seen_value [NUM_TAGS];
    int    seen_cycle [NUM_TAGS];
    int    sent_cycle [NUM_TAGS];
    logic  expected [NUM_TAGS] = '{default: 1'b0};
    word_t expected_value [NUM_TAGS];
    tag_t  active_tags [$];

    rs_top dut (
        .clock          (clock),
        .reset          (reset),
        .squash         (squash),
        .dispatch_valid (dispatch_valid),
        .dispatch_in    (dispatch_in),
        .dispatch_ready (dispatch_ready),
        .cdb_out        (cdb_out)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a result never arrived", cycle);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // scoreboard of broadcasts, one grant per cycle
    always @(negedge clock) begin
        if (!reset && cdb_out.valid) begin
            if (!expected[cdb_out.tag]) begin
                $display("unexpected broadcast of tag %0d at cycle %0d", cdb_out.tag, cycle);
                monitor_errors++;
            end
            seen_count[cdb_out.tag]++;
            seen_value[cdb_out.tag] = cdb_out.value;
            seen_cycle[cdb_out.tag] = cycle;
        end
    end

    //////////////////////////////
    // checks and reference
    task automatic check_cdb(input string name, input cdb_t got, input cdb_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic word_t reference_result(input rs_op_e op, input word_t a, input word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_MUL:  return a * b;
            default: return '0;
        endcase
    endfunction

    function automatic operand_t ready_op(input word_t v);
        operand_t o;
        o.ready = 1'b1;
        o.tag   = '0;
        o.value = v;
        return o;
    endfunction

    function automatic operand_t wait_op(input tag_t t);
        operand_t o;
        o.ready = 1'b0;
        o.tag   = t;
        o.value = '0;
        return o;
    endfunction

    task automatic expect_result(input tag_t t, input word_t v);
        expected[t]       = 1'b1;
        expected_value[t] = v;
        active_tags.push_back(t);
    endtask

    // holds the dispatch until the class has room
    task automatic send(input rs_op_e op, input tag_t dest, input operand_t s1, input operand_t s2);
        @(negedge clock);
        dispatch_in    = '{op: op, dest: dest, src1: s1, src2: s2};
        dispatch_valid = 1'b1;
        #1;
        while (!dispatch_ready) begin
            @(negedge clock);
            #1;
        end
        sent_cycle[dest] = cycle;
        @(posedge clock);
    endtask

    task automatic release_bus();
        @(negedge clock);
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_for_results();
        logic all_seen;
        all_seen = 1'b0;
        while (!all_seen) begin
            @(negedge clock);
            #1;
            all_seen = 1'b1;
            foreach (active_tags[i]) begin
                if (seen_count[active_tags[i]] == 0) all_seen = 1'b0;
            end
        end
        // room for a repeated broadcast to show up
        repeat (6) @(negedge clock);
        #1;
    endtask

    task automatic check_results();
        cdb_t got;
        cdb_t exp;
        foreach (active_tags[i]) begin
            if (seen_count[active_tags[i]] != 1) begin
                $display("tag %0d was broadcast %0d times instead of once",
                         active_tags[i], seen_count[active_tags[i]]);
                errors++;
            end
            got = '{valid: 1'b1, tag: active_tags[i], value: seen_value[active_tags[i]]};
            exp = '{valid: 1'b1, tag: active_tags[i], value: expected_value[active_tags[i]]};
            check_cdb($sformatf("cdb_out tag %0d", active_tags[i]), got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        int now;
        now = errors + monitor_errors;
        tests_run++;
        if (now == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, now - errors_before);
        end
    endtask

    //////////////////////////////
    // tests
    task automatic test_reset();
        int start_errors;
        start_errors = errors + monitor_errors;
        @(negedge clock);
        dispatch_in.op = OP_ADD;
        #1;
        check_ready("dispatch_ready alu", dispatch_ready, 1'b1);
        @(negedge clock);
        dispatch_in.op = OP_MUL;
        #1;
        check_ready("dispatch_ready mul", dispatch_ready, 1'b1);
        repeat (10) begin
            @(negedge clock);
            #1;
            check_ready("cdb_out.valid", cdb_out.valid, 1'b0);
        end
        finish_test("test_reset", start_errors);
    endtask

    task automatic test_alu_ops();
        int     start_errors;
        rs_op_e ops [8];
        word_t  a;
        word_t  b;
        start_errors = errors + monitor_errors;
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL, OP_SRL};
        active_tags.delete();
        foreach (ops[i]) begin
            a = $urandom();
            b = $urandom();
            expect_result(tag_t'(i + 1), reference_result(ops[i], a, b));
            send(ops[i], tag_t'(i + 1), ready_op(a), ready_op(b));
        end
        release_bus();
        wait_for_results();
        check_results();
        finish_test("test_alu_ops", start_errors);
    endtask

    task automatic test_mult();
        int    start_errors;
        word_t a;
        word_t b;
        start_errors = errors + monitor_errors;
        active_tags.delete();
        for (int i = 9; i < 12; i++) begin
            a = $urandom();
            b = $urandom();
            expect_result(tag_t'(i), reference_result(OP_MUL, a, b));
            send(OP_MUL, tag_t'(i), ready_op(a), ready_op(b));
        end
        release_bus();
        wait_for_results();
        check_results();
        foreach (active_tags[i]) begin
            if (seen_cycle[active_tags[i]] - sent_cycle[active_tags[i]] < `RS_MULT_STAGES + 1) begin
                $display("mul tag %0d was broadcast before the multiplier latency", active_tags[i]);
                errors++;
            end
        end
        finish_test("test_mult", start_errors);
    endtask

    task automatic test_dependency();
        int    start_errors;
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        word_t v [12:17];
        start_errors = errors + monitor_errors;
        active_tags.delete();
        a = $urandom();
        b = $urandom();
        c = $urandom();
        d = $urandom();
        v[12] = reference_result(OP_MUL, a, b);
        v[13] = reference_result(OP_ADD, v[12], c);
        v[14] = reference_result(OP_MUL, v[13], v[12]);
        v[15] = reference_result(OP_XOR, v[14], d);
        v[16] = reference_result(OP_SUB, v[15], v[13]);
        v[17] = reference_result(OP_OR, v[15], a);
        for (int t = 12; t < 18; t++) expect_result(tag_t'(t), v[t]);
        send(OP_MUL, 5'd12, ready_op(a), ready_op(b));
        send(OP_ADD, 5'd13, wait_op(5'd12), ready_op(c));
        send(OP_MUL, 5'd14, wait_op(5'd13), wait_op(5'd12));
        send(OP_XOR, 5'd15, wait_op(5'd14), ready_op(d));
        send(OP_SUB, 5'd16, wait_op(5'd15), wait_op(5'd13));
        release_bus();
        // load the consumer in the very cycle tag 15 is on the bus
        do begin
            @(negedge clock);
        end while (!(cdb_out.valid && cdb_out.tag == 5'd15));
        dispatch_in    = '{op: OP_OR, dest: 5'd17, src1: wait_op(5'd15), src2: ready_op(a)};
        dispatch_valid = 1'b1;
        #1;
        check_ready("dispatch_ready bypass", dispatch_ready, 1'b1);
        @(posedge clock);
        release_bus();
        wait_for_results();
        check_results();
        finish_test("test_dependency", start_errors);
    endtask

    task automatic test_full_and_squash();
        int start_errors;
        start_errors = errors + monitor_errors;
        for (int i = 20; i < 24; i++) begin
            send(OP_ADD, tag_t'(i), wait_op(5'd31), ready_op($urandom()));
        end
        @(negedge clock);
        dispatch_valid = 1'b0;
        dispatch_in.op = OP_ADD;
        #1;
        check_ready("dispatch_ready alu full", dispatch_ready, 1'b0);
        @(negedge clock);
        dispatch_in.op = OP_MUL;
        #1;
        check_ready("dispatch_ready mul", dispatch_ready, 1'b1);
        @(negedge clock);
        squash = 1'b1;
        @(negedge clock);
        squash = 1'b0;
        dispatch_in.op = OP_ADD;
        #1;
        check_ready("dispatch_ready alu squashed", dispatch_ready, 1'b1);
        check_ready("cdb_out.valid", cdb_out.valid, 1'b0);
        repeat (20) @(negedge clock);
        #1;
        for (int i = 20; i < 24; i++) begin
            if (seen_count[i] != 0) begin
                $display("tag %0d was broadcast although its operand never arrived", i);
                errors++;
            end
        end
        finish_test("test_full_and_squash", start_errors);
    endtask

    initial begin
        void'($urandom(32'h829c3b2d));
        reset          = 1'b1;
        squash         = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_in    = '0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_reset();
        test_alu_ops();
        test_mult();
        test_dependency();
        test_full_and_squash();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 errors + monitor_errors);
        if (errors + monitor_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/rs_top.sv
/*
 * reservation station top: sorts dispatches into the ALU or multiplier pool,
 * loads the lowest idle slot and loops the result broadcast back as wakeup
 */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module rs_top import rs_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      squash,
    input  logic      dispatch_valid,
    input  dispatch_t dispatch_in,
    output logic      dispatch_ready,
    output cdb_t      cdb_out
);

    localparam int NUM_UNITS = `RS_NUM_ALU + `RS_NUM_MULT;

    // ALU slots first, then multiplier slots
    logic         [NUM_UNITS-1:0] class_mask;
    logic         [NUM_UNITS-1:0] idle;
    logic         [NUM_UNITS-1:0] load;
    logic         [NUM_UNITS-1:0] issue_start;
    logic         [NUM_UNITS-1:0] grant;
    issue_t       [NUM_UNITS-1:0] issue;
    unit_result_t [NUM_UNITS-1:0] results;
    logic                         is_mult;

    //////////////////////////////
    // allocation
    assign is_mult = (dispatch_in.op == OP_MUL);

    always_comb begin
        for (int i = 0; i < NUM_UNITS; i++) begin
            class_mask[i] = is_mult ? (i >= `RS_NUM_ALU) : (i < `RS_NUM_ALU);
        end
    end

    assign dispatch_ready = |(idle & class_mask);

    // lowest idle slot of the class
    always_comb begin
        logic taken;
        taken = 1'b0;
        load  = '0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (!taken && idle[i] && class_mask[i]) begin
                load[i] = dispatch_valid;
                taken   = 1'b1;
            end
        end
    end

    //////////////////////////////
    // slots and units
    for (genvar i = 0; i < NUM_UNITS; i++) begin : g_slot
        rs_slot u_slot (
            .clock       (clock),
            .reset       (reset),
            .squash      (squash),
            .load        (load[i]),
            .load_data   (dispatch_in),
            .wakeup      (cdb_out),
            .granted     (grant[i]),
            .idle        (idle[i]),
            .issue_start (issue_start[i]),
            .issue       (issue[i])
        );
    end

    for (genvar i = 0; i < `RS_NUM_ALU; i++) begin : g_alu
        alu_unit u_alu (
            .clock   (clock),
            .reset   (reset),
            .squash  (squash),
            .start   (issue_start[i]),
            .issue   (issue[i]),
            .granted (grant[i]),
            .result  (results[i])
        );
    end

    for (genvar i = 0; i < `RS_NUM_MULT; i++) begin : g_mult
        localparam int U = `RS_NUM_ALU + i;
        mult_unit u_mult (
            .clock   (clock),
            .reset   (reset),
            .squash  (squash),
            .start   (issue_start[U]),
            .issue   (issue[U]),
            .granted (grant[U]),
            .result  (results[U])
        );
    end

    result_select #(.NUM_UNITS(NUM_UNITS)) u_select (
        .clock   (clock),
        .reset   (reset),
        .squash  (squash),
        .results (results),
        .grant   (grant),
        .cdb_out (cdb_out)
    );

    // a loaded slot holds the instruction on the next cycle
    a_load_idle: assert property (@(posedge clock) disable iff (reset || squash)
        (|load) |=> (($past(load) & idle) == '0));

endmodule

`default_nettype wire

// File: source/rs_slot.sv
/*
 * one reservation station slot, paired with a single functional unit;
 * holds an instruction until its operands wake and its result is granted
 */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module rs_slot import rs_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      squash,
    input  logic      load,
    input  dispatch_t load_data,
    input  cdb_t      wakeup,
    input  logic      granted,
    output logic      idle,
    output logic      issue_start,
    output issue_t    issue
);

    slot_state_e             state;
    rs_op_e                  op_q;
    logic [`RS_TAG_BITS-1:0] dest_q;
    operand_t                src1_q;
    operand_t                src2_q;

    // capture a matching broadcast into a waiting operand
    function automatic operand_t wake(operand_t src, cdb_t bus);
        operand_t res;
        res = src;
        if (src.tag == {`RS_TAG_BITS{1'b0}}) begin
            res.ready = 1'b1;
        end else if (!src.ready && bus.valid && bus.tag == src.tag) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    assign idle        = (state == SLOT_IDLE);
    assign issue_start = (state == SLOT_WAITING) && src1_q.ready && src2_q.ready;

    assign issue.op     = op_q;
    assign issue.dest   = dest_q;
    assign issue.value1 = src1_q.value;
    assign issue.value2 = src2_q.value;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            state <= SLOT_IDLE;
        end else begin
            case (state)
                SLOT_IDLE:      if (load) state <= SLOT_WAITING;
                SLOT_WAITING:   if (issue_start) state <= SLOT_EXECUTING;
                SLOT_EXECUTING: if (granted) state <= SLOT_IDLE;
                default:        state <= SLOT_IDLE;
            endcase
        end
    end

    // bypass from the bus applies at load as well
    always_ff @(posedge clock) begin
        if (load) begin
            op_q   <= load_data.op;
            dest_q <= load_data.dest;
            src1_q <= wake(load_data.src1, wakeup);
            src2_q <= wake(load_data.src2, wakeup);
        end else if (state == SLOT_WAITING) begin
            src1_q <= wake(src1_q, wakeup);
            src2_q <= wake(src2_q, wakeup);
        end
    end

    // the unit is only granted while its instruction executes
    a_grant_executing: assert property (@(posedge clock) disable iff (reset || squash)
        granted |-> (state == SLOT_EXECUTING));

endmodule

`default_nettype wire

// File: source/result_select.sv
/*
 * round-robin pick of one finished unit per cycle; the grant goes back
 * to the units and slots and the granted result drives the broadcast bus
 */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module result_select import rs_pkg::*; #(
    parameter int NUM_UNITS = `RS_NUM_ALU + `RS_NUM_MULT
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         squash,
    input  unit_result_t [NUM_UNITS-1:0] results,
    output logic         [NUM_UNITS-1:0] grant,
    output cdb_t                         cdb_out
);

    localparam int IDX_W = (NUM_UNITS > 1) ? $clog2(NUM_UNITS) : 1;

    logic [NUM_UNITS-1:0] done_vec;
    logic [IDX_W-1:0]     last_q;
    logic [IDX_W-1:0]     pick;
    logic                 found;

    always_comb begin
        for (int i = 0; i < NUM_UNITS; i++) done_vec[i] = results[i].done;
    end

    // search starts at the unit after the last grant
    always_comb begin
        int idx;
        grant = '0;
        pick  = last_q;
        found = 1'b0;
        for (int i = 1; i <= NUM_UNITS; i++) begin
            idx = int'(last_q) + i;
            if (idx >= NUM_UNITS) idx = idx - NUM_UNITS;
            if (!found && done_vec[idx]) begin
                found = 1'b1;
                pick  = IDX_W'(idx);
            end
        end
        if (found) grant[pick] = 1'b1;
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            last_q <= IDX_W'(NUM_UNITS - 1);
        end else if (found) begin
            last_q <= pick;
        end
    end

    assign cdb_out.valid = found;
    assign cdb_out.tag   = results[pick].tag;
    assign cdb_out.value = results[pick].value;

    // a finished unit that loses the round keeps its result
    a_done_held: assert property (@(posedge clock) disable iff (reset || squash)
        (|(done_vec & ~grant)) |=> ((($past(done_vec) & ~$past(grant)) & ~done_vec) == '0));

endmodule

`default_nettype wire

// File: source/mult_unit.sv
/*
 * fixed-latency multiplier for one slot; holds a single item
 * and keeps the low product bits until the selector grants them
 */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module mult_unit import rs_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         squash,
    input  logic         start,
    input  issue_t       issue,
    input  logic         granted,
    output unit_result_t result
);

    localparam int CNT_W = $clog2(`RS_MULT_STAGES + 1);

    logic                    busy;
    logic                    done_q;
    logic [CNT_W-1:0]        count;
    logic                    last_stage;
    logic [`RS_XLEN-1:0]     a_q;
    logic [`RS_XLEN-1:0]     b_q;
    logic [`RS_TAG_BITS-1:0] tag_q;
    logic [`RS_XLEN-1:0]     value_q;

    assign last_stage = busy && (count == CNT_W'(`RS_MULT_STAGES - 1));

    //////////////////////////////
    // stage counter
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy   <= 1'b0;
            done_q <= 1'b0;
            count  <= '0;
        end else begin
            if (start) begin
                busy  <= 1'b1;
                count <= CNT_W'(1);
            end else if (busy) begin
                count <= count + 1'b1;
                if (last_stage) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end
            if (granted) done_q <= 1'b0;
        end
    end

    //////////////////////////////
    // operands and product
    always_ff @(posedge clock) begin
        if (start) begin
            a_q   <= issue.value1;
            b_q   <= issue.value2;
            tag_q <= issue.dest;
        end
        // only the low half is kept
        if (last_stage) value_q <= a_q * b_q;
    end

    assign result.done  = done_q;
    assign result.tag   = tag_q;
    assign result.value = value_q;

    // the paired slot only starts a mul once the previous one is gone
    a_start_free: assert property (@(posedge clock) disable iff (reset)
        start |-> !busy && !done_q && issue.op == OP_MUL);

endmodule

`default_nettype wire

// File: source/alu_unit.sv
/*
 * single-cycle integer ALU for one slot; the result is registered
 * and offered to the selector until it is granted
 */
`timescale 1ns/1ps
`default_nettype none

`include "rs_settings.svh"

module alu_unit import rs_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         squash,
    input  logic         start,
    input  issue_t       issue,
    input  logic         granted,
    output unit_result_t result
);

    logic [`RS_XLEN-1:0]     alu_out;
    logic                    done_q;
    logic [`RS_TAG_BITS-1:0] tag_q;
    logic [`RS_XLEN-1:0]     value_q;

    always_comb begin
        case (issue.op)
            OP_ADD:  alu_out = issue.value1 + issue.value2;
            OP_SUB:  alu_out = issue.value1 - issue.value2;
            OP_AND:  alu_out = issue.value1 & issue.value2;
            OP_OR:   alu_out = issue.value1 | issue.value2;
            OP_XOR:  alu_out = issue.value1 ^ issue.value2;
            OP_SLT:  alu_out = {{(`RS_XLEN-1){1'b0}},
                                $signed(issue.value1) < $signed(issue.value2)};
            OP_SLL:  alu_out = issue.value1 << issue.value2[4:0];
            OP_SRL:  alu_out = issue.value1 >> issue.value2[4:0];
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            done_q <= 1'b0;
        end else if (start) begin
            done_q <= 1'b1;
        end else if (granted) begin
            done_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            tag_q   <= issue.dest;
            value_q <= alu_out;
        end
    end

    assign result.done  = done_q;
    assign result.tag   = tag_q;
    assign result.value = value_q;

endmodule

`default_nettype wire

// File: source/rs_pkg.sv
/*
 * shared types of the reservation station: opcodes, slot states
 * and the packed structs passed between slots, units and the selector
 */
`default_nettype none

`include "rs_settings.svh"

package rs_pkg;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_SRL,
        OP_MUL
    } rs_op_e;

    typedef enum logic [1:0] {
        SLOT_IDLE,
        SLOT_WAITING,
        SLOT_EXECUTING
    } slot_state_e;

    // tag zero means the value is already valid
    typedef struct packed {
        logic                    ready;
        logic [`RS_TAG_BITS-1:0] tag;
        logic [`RS_XLEN-1:0]     value;
    } operand_t;

    typedef struct packed {
        rs_op_e                  op;
        logic [`RS_TAG_BITS-1:0] dest;
        operand_t                src1;
        operand_t                src2;
    } dispatch_t;

    typedef struct packed {
        rs_op_e                  op;
        logic [`RS_TAG_BITS-1:0] dest;
        logic [`RS_XLEN-1:0]     value1;
        logic [`RS_XLEN-1:0]     value2;
    } issue_t;

    typedef struct packed {
        logic                    valid;
        logic [`RS_TAG_BITS-1:0] tag;
        logic [`RS_XLEN-1:0]     value;
    } cdb_t;

    typedef struct packed {
        logic                    done;
        logic [`RS_TAG_BITS-1:0] tag;
        logic [`RS_XLEN-1:0]     value;
    } unit_result_t;

endpackage

`default_nettype wire

// File: source/rs_settings.svh
/*
 * sizing of the reservation station datapath and pools,
 * included by the package and by every module that needs a width
 */
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// datapath widths
`define RS_XLEN 32
`define RS_TAG_BITS 5

// pool sizes, one functional unit per slot
`define RS_NUM_ALU 4
`define RS_NUM_MULT 2

// cycles from multiplier start to done
// the stage counter assumes at least 2
`define RS_MULT_STAGES 3

`endif
